//--- sources.f
+incdir+common
common/dma_pkg.sv
rtl/dma_stream_fifo.sv
rtl/dma_zero_reject.sv
rtl/dma_req_fork.sv
datapath/dma_read_dp.sv
datapath/dma_byte_buffer.sv
datapath/dma_write_dp.sv
rtl/dma_backend.sv
tb/tb_dma_backend.sv

//--- Makefile
# Verilator simulation of the byte-copy engine
VERILATOR ?= verilator
TOP       ?= tb_dma_backend
FLIST     ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/tb_dma_backend.sv
`include "dma_macros.svh"

module tb_dma_backend;
    timeunit 1ns;
    timeprecision 100ps;
    import dma_pkg::*;

    localparam int BusBytes = `DMA_BUS_BYTES;
    // Cycles any single wait may take
    localparam int Timeout = 1000;

    // One row per transfer
    typedef struct packed {
        offset_t src_off;
        offset_t dst_off;
        len_t    length;
        logic    last;
        logic    back_pressure;
    } entry_t;

    localparam int NumEntries = 7;
    localparam entry_t Entries [NumEntries] = '{
        // Aligned copy of two full beats
        '{2'd0, 2'd0, 12'd8, 1'b1, 1'b0},
        // Misaligned on both sides
        '{2'd3, 2'd1, 12'd7, 1'b0, 1'b0},
        // Zero length answered with an error
        '{2'd0, 2'd0, 12'd0, 1'b1, 1'b0},
        // Longer copy with write stalls
        '{2'd2, 2'd3, 12'd21, 1'b1, 1'b1},
        // Back to back with alternating last flags
        '{2'd0, 2'd2, 12'd5, 1'b0, 1'b0},
        '{2'd1, 2'd0, 12'd6, 1'b1, 1'b0},
        '{2'd3, 2'd3, 12'd9, 1'b0, 1'b0}
    };

    logic         clk_i, reset_i;
    dma_req_t     req_i;
    logic         req_valid_i, req_ready_o;
    dma_rsp_t     rsp_o;
    logic         rsp_valid_o;
    stream_beat_t read_beat_i, write_beat_o;
    logic         read_valid_i, read_ready_o;
    logic         write_valid_o, write_ready_i;

    // Source payload in order and responses still owed
    logic [7:0] exp_bytes[$];
    dma_rsp_t   exp_rsp[$];

    dma_backend i_dut (.*);

    always #5 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_beat(stream_beat_t act, stream_beat_t exp);
        data_t mask;
        for (int i = 0; i < BusBytes; i++) begin
            mask[8*i +: 8] = {8{exp.strb[i]}};
        end
        // Only strobed bytes carry meaning
        if (act.strb !== exp.strb || act.last !== exp.last || (act.data & mask) !== exp.data) begin
            abort_run($sformatf("** Error @ %0d ns: write beat %h/%b/%b, expected %h/%b/%b",
                $time, act.data & mask, act.strb, act.last, exp.data, exp.strb, exp.last));
        end
    endtask

    task automatic check_rsp(dma_rsp_t act, dma_rsp_t exp);
        if (act !== exp) begin
            abort_run($sformatf("** Error @ %0d ns: response last %b error %b, expected %b %b",
                $time, act.last, act.error, exp.last, exp.error));
        end
    endtask

    // ------------------------------------------------------------
    // Models
    // ------------------------------------------------------------
    task automatic drive_requests();
        int waited;
        for (int n = 0; n < NumEntries; n++) begin
            req_i.src_addr = addr_t'(n * 64 + int'(Entries[n].src_off));
            req_i.dst_addr = addr_t'(16'h8000 + n * 64 + int'(Entries[n].dst_off));
            req_i.length   = Entries[n].length;
            req_i.last     = Entries[n].last;
            if (Entries[n].length != '0) begin
                exp_rsp.push_back(dma_rsp_t'{last: Entries[n].last, error: 1'b0});
            end
            req_valid_i = 1'b1;
            waited = 0;
            @(negedge clk_i);
            while (!req_ready_o) begin
                waited++;
                if (waited > Timeout) abort_run("Timeout: a request was never accepted");
                @(negedge clk_i);
            end
            @(posedge clk_i);
            #1;
        end
        req_valid_i = 1'b0;
    endtask

    task automatic feed_source();
        logic [31:0]  rng;
        int           nbeats, pos, lo, hi, waited;
        stream_beat_t beat;
        rng = 32'd27;
        for (int n = 0; n < NumEntries; n++) begin
            lo = int'(Entries[n].src_off);
            hi = lo + int'(Entries[n].length);
            nbeats = (hi + BusBytes - 1) / BusBytes;
            for (int k = 0; k < nbeats; k++) begin
                // Random idle cycle before a beat
                rng = xorshift(rng);
                if (rng[1:0] == 2'b00) begin
                    read_valid_i = 1'b0;
                    @(posedge clk_i);
                    #1;
                end
                beat = '0;
                for (int i = 0; i < BusBytes; i++) begin
                    pos = k * BusBytes + i;
                    rng = xorshift(rng);
                    beat.data[8*i +: 8] = rng[7:0];
                    if (pos >= lo && pos < hi) begin
                        beat.strb[i] = 1'b1;
                        exp_bytes.push_back(rng[7:0]);
                    end
                end
                beat.last = k == nbeats - 1;
                read_beat_i  = beat;
                read_valid_i = 1'b1;
                waited = 0;
                @(negedge clk_i);
                while (!read_ready_o) begin
                    waited++;
                    if (waited > Timeout) abort_run("Timeout: a source beat was never taken");
                    @(negedge clk_i);
                end
                @(posedge clk_i);
                #1;
            end
        end
        read_valid_i = 1'b0;
    endtask

    task automatic collect_sink();
        logic [31:0]  rng;
        int           nbeats, pos, lo, hi, waited;
        stream_beat_t got, exp;
        rng = 32'd27;
        for (int n = 0; n < NumEntries; n++) begin
            lo = int'(Entries[n].dst_off);
            hi = lo + int'(Entries[n].length);
            nbeats = (hi + BusBytes - 1) / BusBytes;
            for (int k = 0; k < nbeats; k++) begin
                waited = 0;
                rng = xorshift(rng);
                write_ready_i = !Entries[n].back_pressure || rng[0];
                @(negedge clk_i);
                while (!(write_valid_o && write_ready_i)) begin
                    waited++;
                    if (waited > Timeout) abort_run("Timeout: an expected write beat never came");
                    @(posedge clk_i);
                    #1;
                    rng = xorshift(rng);
                    write_ready_i = !Entries[n].back_pressure || rng[0];
                    @(negedge clk_i);
                end
                got = write_beat_o;
                @(posedge clk_i);
                #1;
                // Payload lands from the destination offset on
                exp = '0;
                for (int i = 0; i < BusBytes; i++) begin
                    pos = k * BusBytes + i;
                    if (pos >= lo && pos < hi) begin
                        if (exp_bytes.size() == 0) begin
                            abort_run("Write beat ran ahead of the source data");
                        end
                        exp.strb[i] = 1'b1;
                        exp.data[8*i +: 8] = exp_bytes.pop_front();
                    end
                end
                exp.last = k == nbeats - 1;
                check_beat(got, exp);
            end
        end
        write_ready_i = 1'b1;
    endtask

    task automatic watch_responses();
        forever begin
            @(negedge clk_i);
            // Zero length answers in its own acceptance cycle
            if (req_valid_i && req_ready_o && req_i.length == '0) begin
                if (!rsp_valid_o) abort_run("Zero-length request accepted without a response");
                check_rsp(rsp_o, dma_rsp_t'{last: 1'b1, error: 1'b1});
            end else if (rsp_valid_o) begin
                if (exp_rsp.size() == 0) abort_run("Response came with no transfer outstanding");
                check_rsp(rsp_o, exp_rsp.pop_front());
            end
        end
    endtask

    initial begin
        int waited;
        clk_i = 1'b0;
        reset_i = 1'b1;
        req_i = '0;
        req_valid_i = 1'b0;
        read_beat_i = '0;
        read_valid_i = 1'b0;
        write_ready_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        reset_i = 1'b0;
        fork
            watch_responses();
        join_none
        fork
            drive_requests();
            feed_source();
            collect_sink();
        join
        waited = 0;
        @(negedge clk_i);
        while (exp_rsp.size() != 0) begin
            waited++;
            if (waited > Timeout) abort_run("Timeout: responses still missing at the end");
            @(negedge clk_i);
        end
        // Quiet bus after the last transfer
        repeat (10) begin
            @(negedge clk_i);
            if (write_valid_o || rsp_valid_o) abort_run("Stray write beat or response at the end");
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- rtl/dma_backend.sv
`include "dma_macros.svh"

module dma_backend (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  dma_pkg::dma_req_t     req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    output dma_pkg::dma_rsp_t     rsp_o,
    output logic                  rsp_valid_o,
    input  dma_pkg::stream_beat_t read_beat_i,
    input  logic                  read_valid_i,
    output logic                  read_ready_o,
    output dma_pkg::stream_beat_t write_beat_o,
    output logic                  write_valid_o,
    input  logic                  write_ready_i
);
    import dma_pkg::*;

    // Zero-length filter to fork
    logic fwd_valid, fwd_ready;
    // Fork to the request FIFOs
    dp_req_t r_req, w_req;
    logic r_valid, r_ready, w_valid, w_ready;
    // Request FIFOs to the datapaths
    dp_req_t r_dp_req, w_dp_req;
    logic r_dp_valid, r_dp_ready, w_dp_valid, w_dp_ready;
    // Last-flag store
    logic last_push, last_ready, last_flag, last_valid;
    // Reorder buffer
    logic push, pop;
    byte_cnt_t push_cnt, pop_cnt;
    data_t push_data, head_data;
    buf_cnt_t free, fill;
    logic wr_done;

    // ------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------
    dma_zero_reject i_zero_reject (
        .clk_i, .reset_i, .req_i, .req_valid_i, .req_ready_o,
        .fwd_valid_o (fwd_valid), .fwd_ready_i (fwd_ready),
        .done_i (wr_done & last_valid), .done_last_i (last_flag),
        .rsp_o, .rsp_valid_o
    );

    dma_req_fork i_req_fork (
        .clk_i, .reset_i, .req_i,
        .valid_i (fwd_valid), .ready_o (fwd_ready),
        .r_req_o (r_req), .w_req_o (w_req),
        .r_valid_o (r_valid), .w_valid_o (w_valid),
        .r_ready_i (r_ready), .w_ready_i (w_ready),
        .last_ready_i (last_ready), .last_push_o (last_push)
    );

    // Decoupling between the fork and each datapath side
    dma_stream_fifo #(.WIDTH($bits(dp_req_t)), .DEPTH(`DMA_NUM_IN_FLIGHT)) i_r_req_fifo (
        .clk_i, .reset_i,
        .data_i (r_req), .valid_i (r_valid), .ready_o (r_ready),
        .data_o (r_dp_req), .valid_o (r_dp_valid), .ready_i (r_dp_ready)
    );

    dma_stream_fifo #(.WIDTH($bits(dp_req_t)), .DEPTH(`DMA_NUM_IN_FLIGHT)) i_w_req_fifo (
        .clk_i, .reset_i,
        .data_i (w_req), .valid_i (w_valid), .ready_o (w_ready),
        .data_o (w_dp_req), .valid_o (w_dp_valid), .ready_i (w_dp_ready)
    );

    // Pairs each write completion with its request's last flag
    dma_stream_fifo #(.WIDTH(1), .DEPTH(`DMA_LAST_DEPTH)) i_last_fifo (
        .clk_i, .reset_i,
        .data_i (req_i.last), .valid_i (last_push), .ready_o (last_ready),
        .data_o (last_flag), .valid_o (last_valid), .ready_i (wr_done)
    );

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    dma_read_dp i_read_dp (
        .clk_i, .reset_i,
        .req_i (r_dp_req), .req_valid_i (r_dp_valid), .req_ready_o (r_dp_ready),
        .beat_i (read_beat_i), .beat_valid_i (read_valid_i), .beat_ready_o (read_ready_o),
        .free_i (free), .push_o (push), .push_cnt_o (push_cnt), .push_data_o (push_data)
    );

    dma_byte_buffer i_byte_buffer (
        .clk_i, .reset_i,
        .push_i (push), .push_cnt_i (push_cnt), .push_data_i (push_data), .free_o (free),
        .pop_i (pop), .pop_cnt_i (pop_cnt), .fill_o (fill), .head_data_o (head_data)
    );

    dma_write_dp i_write_dp (
        .clk_i, .reset_i,
        .req_i (w_dp_req), .req_valid_i (w_dp_valid), .req_ready_o (w_dp_ready),
        .fill_i (fill), .head_data_i (head_data), .pop_o (pop), .pop_cnt_o (pop_cnt),
        .beat_o (write_beat_o), .beat_valid_o (write_valid_o), .beat_ready_i (write_ready_i),
        .done_o (wr_done)
    );

endmodule

//--- datapath/dma_write_dp.sv
`include "dma_macros.svh"

module dma_write_dp (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  dma_pkg::dp_req_t      req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  dma_pkg::buf_cnt_t     fill_i,
    input  dma_pkg::data_t        head_data_i,
    output logic                  pop_o,
    output dma_pkg::byte_cnt_t    pop_cnt_o,
    output dma_pkg::stream_beat_t beat_o,
    output logic                  beat_valid_o,
    input  logic                  beat_ready_i,
    output logic                  done_o
);
    import dma_pkg::*;

    len_t      remaining_q;
    offset_t   offset_q;
    logic      first_q;
    logic      done_q;
    offset_t   start;
    byte_cnt_t avail;
    data_t     shifted;

    // Slot of the first byte and the byte count of the current beat
    always_comb begin
        start     = first_q ? offset_q : '0;
        avail     = byte_cnt_t'(`DMA_BUS_BYTES) - byte_cnt_t'(start);
        pop_cnt_o = (remaining_q < len_t'(avail)) ? byte_cnt_t'(remaining_q) : avail;
    end

    assign req_ready_o = remaining_q == '0;
    // Offer the beat once the buffer has all of its bytes
    assign beat_valid_o = !req_ready_o && (fill_i >= buf_cnt_t'(pop_cnt_o));
    assign pop_o = beat_valid_o && beat_ready_i;

    // Move head bytes up to the destination slot
    assign shifted = head_data_i << {start, 3'b000};

    always_comb begin
        for (int i = 0; i < `DMA_BUS_BYTES; i++) begin
            beat_o.strb[i] = (i >= int'(start)) && (i < int'(start) + int'(pop_cnt_o));
            // Bytes outside the strobe stay zero
            beat_o.data[8*i +: 8] = beat_o.strb[i] ? shifted[8*i +: 8] : 8'h00;
        end
        beat_o.last = len_t'(pop_cnt_o) == remaining_q;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            remaining_q <= '0;
            first_q     <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            done_q <= pop_o && beat_o.last;
            if (req_valid_i && req_ready_o) begin
                remaining_q <= req_i.length;
                first_q     <= 1'b1;
            end else if (pop_o) begin
                remaining_q <= remaining_q - len_t'(pop_cnt_o);
                first_q     <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            offset_q <= req_i.offset;
        end
    end

    assign done_o = done_q;

    // A stalled beat holds its bytes, strobes and last until it is taken
    a_beat_held: assert property (@(posedge clk_i) disable iff (reset_i)
        beat_valid_o && !beat_ready_i |=> beat_valid_o && $stable(beat_o));

endmodule

//--- datapath/dma_byte_buffer.sv
`include "dma_macros.svh"

module dma_byte_buffer (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic               push_i,
    input  dma_pkg::byte_cnt_t push_cnt_i,
    input  dma_pkg::data_t     push_data_i,
    output dma_pkg::buf_cnt_t  free_o,
    input  logic               pop_i,
    input  dma_pkg::byte_cnt_t pop_cnt_i,
    output dma_pkg::buf_cnt_t  fill_o,
    output dma_pkg::data_t     head_data_o
);
    import dma_pkg::*;

    localparam int unsigned Size     = `DMA_BUS_BYTES * `DMA_BUFFER_BEATS;
    localparam int unsigned PtrWidth = $clog2(Size);

    logic [7:0]          mem_q [Size];
    logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
    buf_cnt_t            fill_q;

    // Ring pointer advance; the ring size need not be a power of two
    function automatic logic [PtrWidth-1:0] ptr_add(logic [PtrWidth-1:0] ptr, int unsigned inc);
        int unsigned sum;
        sum = int'(ptr) + inc;
        if (sum >= Size) begin
            sum = sum - Size;
        end
        return PtrWidth'(sum);
    endfunction

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            for (int unsigned i = 0; i < `DMA_BUS_BYTES; i++) begin
                if (i < int'(push_cnt_i)) begin
                    mem_q[ptr_add(wr_ptr_q, i)] <= push_data_i[8*i +: 8];
                end
            end
        end
    end

    // Oldest bytes in order, byte zero at the bottom
    always_comb begin
        for (int unsigned i = 0; i < `DMA_BUS_BYTES; i++) begin
            head_data_o[8*i +: 8] = mem_q[ptr_add(rd_ptr_q, i)];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= ptr_add(wr_ptr_q, int'(push_cnt_i));
            end
            if (pop_i) begin
                rd_ptr_q <= ptr_add(rd_ptr_q, int'(pop_cnt_i));
            end
            fill_q <= fill_q + (push_i ? buf_cnt_t'(push_cnt_i) : '0)
                             - (pop_i ? buf_cnt_t'(pop_cnt_i) : '0);
        end
    end

    assign fill_o = fill_q;
    assign free_o = buf_cnt_t'(Size) - fill_q;

    // The datapaths size their requests from the reported counts
    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        push_i |-> buf_cnt_t'(push_cnt_i) <= free_o);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
        pop_i |-> buf_cnt_t'(pop_cnt_i) <= fill_o);

endmodule

//--- datapath/dma_read_dp.sv
`include "dma_macros.svh"

module dma_read_dp (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  dma_pkg::dp_req_t      req_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  dma_pkg::stream_beat_t beat_i,
    input  logic                  beat_valid_i,
    output logic                  beat_ready_o,
    input  dma_pkg::buf_cnt_t     free_i,
    output logic                  push_o,
    output dma_pkg::byte_cnt_t    push_cnt_o,
    output dma_pkg::data_t        push_data_o
);
    import dma_pkg::*;

    // Bytes of the active transfer still to come, zero when idle
    len_t      remaining_q;
    offset_t   offset_q;
    logic      first_q;
    offset_t   start;
    byte_cnt_t avail;

    // First payload byte of this beat and the payload bytes it carries
    always_comb begin
        start      = first_q ? offset_q : '0;
        avail      = byte_cnt_t'(`DMA_BUS_BYTES) - byte_cnt_t'(start);
        push_cnt_o = (remaining_q < len_t'(avail)) ? byte_cnt_t'(remaining_q) : avail;
    end

    assign req_ready_o = remaining_q == '0;
    // Only take a beat when a full beat fits
    assign beat_ready_o = !req_ready_o && (free_i >= buf_cnt_t'(`DMA_BUS_BYTES));
    assign push_o = beat_valid_i && beat_ready_o;
    // Compact payload down to byte zero; bytes past the length are ignored by the count
    assign push_data_o = beat_i.data >> {start, 3'b000};

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            remaining_q <= '0;
            first_q     <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            remaining_q <= req_i.length;
            first_q     <= 1'b1;
        end else if (push_o) begin
            remaining_q <= remaining_q - len_t'(push_cnt_o);
            first_q     <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            offset_q <= req_i.offset;
        end
    end

    // Source last must mark the beat that ends the transfer
    a_src_last: assert property (@(posedge clk_i) disable iff (reset_i)
        push_o && beat_i.last |-> len_t'(push_cnt_o) == remaining_q);

endmodule

//--- rtl/dma_req_fork.sv
module dma_req_fork (
    input  logic              clk_i,
    input  logic              reset_i,
    input  dma_pkg::dma_req_t req_i,
    input  logic              valid_i,
    output logic              ready_o,
    output dma_pkg::dp_req_t  r_req_o,
    output dma_pkg::dp_req_t  w_req_o,
    output logic              r_valid_o,
    output logic              w_valid_o,
    input  logic              r_ready_i,
    input  logic              w_ready_i,
    input  logic              last_ready_i,
    output logic              last_push_o
);
    import dma_pkg::*;

    // Side has already accepted the current request
    logic r_taken_q, w_taken_q;
    logic r_done, w_done;

    // Low address bits give the byte offset in the first beat
    assign r_req_o = '{offset: offset_t'(req_i.src_addr), length: req_i.length};
    assign w_req_o = '{offset: offset_t'(req_i.dst_addr), length: req_i.length};

    assign r_valid_o = valid_i && !r_taken_q;
    // Write side also needs a slot in the last-flag store
    assign w_valid_o = valid_i && !w_taken_q && last_ready_i;
    assign last_push_o = w_valid_o && w_ready_i;

    assign r_done = r_taken_q || (r_valid_o && r_ready_i);
    assign w_done = w_taken_q || last_push_o;
    // Consumed once both sides hold a copy
    assign ready_o = r_done && w_done;

    always_ff @(posedge clk_i) begin
        if (reset_i || (valid_i && ready_o)) begin
            r_taken_q <= 1'b0;
            w_taken_q <= 1'b0;
        end else begin
            r_taken_q <= r_done;
            w_taken_q <= w_done;
        end
    end

    // A partly taken request stays posted and unchanged until both sides hold it
    a_taken_held: assert property (@(posedge clk_i) disable iff (reset_i)
        r_taken_q || w_taken_q |-> valid_i && $stable(req_i));

endmodule

//--- rtl/dma_zero_reject.sv
module dma_zero_reject (
    input  logic              clk_i,
    input  logic              reset_i,
    input  dma_pkg::dma_req_t req_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    output logic              fwd_valid_o,
    input  logic              fwd_ready_i,
    input  logic              done_i,
    input  logic              done_last_i,
    output dma_pkg::dma_rsp_t rsp_o,
    output logic              rsp_valid_o
);
    import dma_pkg::*;

    logic is_zero;
    logic zero_accept;

    assign is_zero = req_i.length == '0;

    // Zero-length requests never reach the datapath
    assign fwd_valid_o = req_valid_i && !is_zero;

    // A completion owns the response slot and holds back a zero request
    assign req_ready_o = is_zero ? !done_i : fwd_ready_i;
    assign zero_accept = req_valid_i && is_zero && req_ready_o;

    // Merge the synthesized error response with normal completions
    always_comb begin
        rsp_valid_o = done_i || zero_accept;
        rsp_o.last  = done_i ? done_last_i : 1'b1;
        rsp_o.error = zero_accept;
    end

    // A zero request that meets a completion stays posted for a later cycle
    a_zero_held: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i && is_zero && done_i |=> req_valid_i && $stable(req_i));

endmodule

//--- rtl/dma_stream_fifo.sv
module dma_stream_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 2
) (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             valid_i,
    output logic             ready_o,
    output logic [WIDTH-1:0] data_o,
    output logic             valid_o,
    input  logic             ready_i
);
    localparam int unsigned PtrWidth = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CntWidth = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]    mem_q [DEPTH];
    logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                push, pop;

    assign ready_o = count_q != CntWidth'(DEPTH);
    assign valid_o = count_q != '0;
    assign data_o  = mem_q[rd_ptr_q];

    assign push = valid_i && ready_o;
    assign pop  = valid_o && ready_i;

    // Storage array indexed by the ring pointers
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CntWidth'(push) - CntWidth'(pop);
        end
    end

    // A word offered to a full FIFO stays offered until there is room
    a_held_while_full: assert property (@(posedge clk_i) disable iff (reset_i)
        valid_i && !ready_o |=> valid_i && $stable(data_i));

endmodule

//--- common/dma_pkg.sv
`include "dma_macros.svh"

package dma_pkg;

    // Byte position inside one beat
    typedef logic [$clog2(`DMA_BUS_BYTES)-1:0] offset_t;
    typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`DMA_LEN_WIDTH-1:0] len_t;
    typedef logic [`DMA_BUS_BYTES*8-1:0] data_t;
    typedef logic [`DMA_BUS_BYTES-1:0] strb_t;

    // Byte count of one beat, zero up to a full beat
    typedef logic [$clog2(`DMA_BUS_BYTES+1)-1:0] byte_cnt_t;
    // Byte count of the whole reorder buffer
    typedef logic [$clog2(`DMA_BUS_BYTES*`DMA_BUFFER_BEATS+1)-1:0] buf_cnt_t;

    // Request from the controlling unit
    typedef struct packed {
        addr_t src_addr;
        addr_t dst_addr;
        len_t  length;
        logic  last;
    } dma_req_t;

    // One response per transfer
    typedef struct packed {
        logic last;
        logic error;
    } dma_rsp_t;

    // Datapath request, same shape on the read and the write side
    typedef struct packed {
        offset_t offset;
        len_t    length;
    } dp_req_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } stream_beat_t;

endpackage

//--- common/dma_macros.svh
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Bytes per stream beat
`define DMA_BUS_BYTES 4

// Address and transfer length widths
`define DMA_ADDR_WIDTH 16
`define DMA_LEN_WIDTH 12

// Request FIFO depth per datapath side
`define DMA_NUM_IN_FLIGHT 2

// Reorder buffer size in beats, three covers misaligned copies
`define DMA_BUFFER_BEATS 3

// Every transfer in the buffer or a request FIFO needs a last-flag slot
`define DMA_LAST_DEPTH (`DMA_BUFFER_BEATS + `DMA_NUM_IN_FLIGHT)

`endif
